// File: armPipe.f
source/isaPkg.sv
source/pipePkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/writebackStage.sv
source/hazardUnit.sv
source/armPipe.sv
tb/clockGen.sv
tb/armPipeTb.sv

// File: build.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module armPipeTb -f armPipe.f -Mdir obj_dir \
   || exit 1

./obj_dir/VarmPipeTb | tee /dev/stderr | grep -q "^Finished with no errors$" && exit 0 || exit 1

// File: tb/armPipeTb.sv
/* Testbench for the pipelined ARM subset processor
   Assembles a program, models memories and checks every store */
module armPipeTb;
   timeunit 1ns;
   timeprecision 1ps;
   import isaPkg::*;

   localparam int    STORE_TIMEOUT = 60;    // Cycles allowed between stores
   localparam int    RESET_TIMEOUT = 20;    // Wakeups allowed before reset falls
   localparam word_t SKIP_A        = 32'h80;
   localparam word_t SKIP_B        = 32'h84;
   localparam word_t FILL          = 32'ha5c3_0000;

   logic   clk;
   logic   reset;
   logic   memWrite;
   word_t  instr, readData, pc, dataAddr, writeData;
   word_t  imem [0:255];
   word_t  dmem [0:255];
   word_t  modelReg [0:15];
   flags_t modelFlags;                      // {N, Z, C, V}
   logic [31:0] lfsrState = 32'h9ea5_d7bc;
   int     emitAddr;
   word_t  expAddr [$];
   word_t  expData [$];
   string  expName [$];

   clockGen clocks (.clk(clk), .reset(reset));

   armPipe UUT (
      .clk(clk), .reset(reset), .instr(instr), .readData(readData),
      .pc(pc), .dataAddr(dataAddr), .writeData(writeData), .memWrite(memWrite)
   );

   // Combinational memories with writes on the rising edge
   assign instr    = imem[pc[9:2]];
   assign readData = dmem[dataAddr[9:2]];

   always @(posedge clk) begin
      if (memWrite) dmem[dataAddr[9:2]] <= writeData;
   end

   task automatic stopOnError(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "stopped at the first error");
   endtask

   assert property (@(posedge clk) reset |-> (pc == '0 && !memWrite))
      else stopOnError("pc or memWrite not at reset value during reset");
   assert property (@(posedge clk) disable iff (reset)
                    memWrite |-> (dataAddr != SKIP_A && dataAddr != SKIP_B))
      else stopOnError("a store skipped by the branch was executed");

   task automatic checkValue(input string name, input word_t expected, input word_t actual);
      assert (actual === expected)
         else begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            stopOnError("value check failed");
         end
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic lfsrBit();
      logic fb;
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      return fb;
   endfunction

   function automatic logic [7:0] randByte();
      logic [7:0] r;
      for (int i = 0; i < 8; i++) r[i] = lfsrBit();
      return r;
   endfunction

   function automatic logic condPass(input cond_t cond, input flags_t f);
      logic n, z, c, v;
      {n, z, c, v} = f;
      case (cond)
         COND_EQ: return z;
         COND_NE: return !z;
         COND_CS: return c;
         COND_CC: return !c;
         COND_MI: return n;
         COND_PL: return !n;
         COND_VS: return v;
         COND_VC: return !v;
         COND_HI: return c && !z;
         COND_LS: return !c || z;
         COND_GE: return n == v;
         COND_LT: return n != v;
         COND_GT: return !z && (n == v);
         COND_LE: return z || (n != v);
         default: return 1'b1;
      endcase
   endfunction

   task automatic emit(input word_t w);
      imem[emitAddr >> 2] = w;
      emitAddr += 4;
   endtask

   // Emits a data-processing instruction and updates the model
   task automatic dataOp(input cond_t cond, input logic [3:0] cmd, input logic immForm,
                         input logic setFlags, input regAddr_t rn, input regAddr_t rd,
                         input logic [7:0] op2);
      word_t       a, b, r;
      logic [32:0] wide;
      a = (rn == REG_PC) ? word_t'(emitAddr) + 32'd8 : modelReg[rn];
      b = immForm ? {24'b0, op2} : modelReg[op2[3:0]];
      emit({cond, 2'b00, immForm, cmd, setFlags, rn, rd, 4'h0, op2});
      if (!condPass(cond, modelFlags)) return;
      wide = '0;
      case (cmd)
         CMD_ADD: wide = {1'b0, a} + {1'b0, b};
         CMD_SUB: wide = {1'b0, a} - {1'b0, b};
         CMD_AND: wide = {1'b0, a & b};
         default: wide = {1'b0, a | b};
      endcase
      r = wide[31:0];
      modelReg[rd] = r;
      if (setFlags) begin
         modelFlags[3] = r[31];
         modelFlags[2] = (r == '0);
         if (cmd == CMD_ADD) begin
            modelFlags[1] = wide[32];
            modelFlags[0] = (a[31] == b[31]) && (r[31] != a[31]);
         end else if (cmd == CMD_SUB) begin
            modelFlags[1] = (a >= b);   // No borrow
            modelFlags[0] = (a[31] != b[31]) && (r[31] != a[31]);
         end
      end
   endtask

   task automatic rawStore(input regAddr_t rd, input logic [11:0] off);
      emit({COND_AL, 2'b01, 6'b011000, 4'd0, rd, off});  // STR rd, [R0, #off]
   endtask

   task automatic storeWord(input regAddr_t rd, input logic [11:0] off, input string name);
      rawStore(rd, off);
      expAddr.push_back({20'b0, off});
      expData.push_back(modelReg[rd]);
      expName.push_back(name);
   endtask

   task automatic loadWord(input regAddr_t rd, input logic [11:0] off);
      emit({COND_AL, 2'b01, 6'b011001, 4'd0, rd, off});
      for (int i = 0; i < expAddr.size(); i++) begin
         if (expAddr[i] == {20'b0, off}) modelReg[rd] = expData[i];  // Latest store wins
      end
   endtask

   task automatic branch(input cond_t cond, input logic [23:0] off);
      emit({cond, 2'b10, 2'b10, off});
   endtask

   task automatic conditionRun(input logic [7:0] y, input logic [11:0] off, input string name);
      dataOp(COND_AL, CMD_ADD, 1'b1, 1'b0, 4'd0, 4'd10, y);
      dataOp(COND_AL, CMD_SUB, 1'b0, 1'b1, 4'd9, 4'd12, 8'd10);  // SUBS R12, R9, R10
      dataOp(COND_EQ, CMD_ADD, 1'b1, 1'b0, 4'd11, 4'd11, 8'd1);
      dataOp(COND_NE, CMD_ADD, 1'b1, 1'b0, 4'd11, 4'd11, 8'd2);
      dataOp(COND_CS, CMD_ADD, 1'b1, 1'b0, 4'd11, 4'd11, 8'd4);
      dataOp(COND_LT, CMD_ADD, 1'b1, 1'b0, 4'd11, 4'd11, 8'd8);
      storeWord(4'd11, off, name);
   endtask

   task automatic waitResetRelease();
      int steps;
      steps = 0;
      do begin
         @(reset or negedge clk);
         steps++;
         if (steps > RESET_TIMEOUT) stopOnError("reset was never released");
      end while (reset !== 1'b0);
   endtask

   task automatic waitStore(output word_t addr, output word_t data);
      int cycles;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         if (cycles > STORE_TIMEOUT) stopOnError("timeout while waiting for a store");
      end while (!memWrite);
      addr = dataAddr;
      data = writeData;
   endtask

   initial begin
      word_t      a, d;
      logic [7:0] x, y;
      string      name;
      emitAddr   = 0;
      modelFlags = '0;
      for (int i = 0; i < 256; i++) begin
         imem[i] = '0;
         dmem[i] = FILL ^ (word_t'(i) << 2);
      end
      for (int i = 0; i < 16; i++) modelReg[i] = '0;

      dataOp(COND_AL, CMD_AND, 1'b1, 1'b0, 4'd0, 4'd0, 8'd0);   // R0 = 0
      // Dependent chain with each result forwarded to the next
      dataOp(COND_AL, CMD_ADD, 1'b1, 1'b0, 4'd0, 4'd1, randByte());
      dataOp(COND_AL, CMD_SUB, 1'b1, 1'b0, 4'd1, 4'd2, randByte());
      dataOp(COND_AL, CMD_AND, 1'b0, 1'b0, 4'd2, 4'd3, 8'd1);
      dataOp(COND_AL, CMD_ORR, 1'b1, 1'b0, 4'd3, 4'd4, randByte());
      dataOp(COND_AL, CMD_ADD, 1'b0, 1'b0, 4'd4, 4'd5, 8'd2);
      dataOp(COND_AL, CMD_SUB, 1'b0, 1'b0, 4'd5, 4'd6, 8'd3);
      dataOp(COND_AL, CMD_AND, 1'b1, 1'b0, 4'd6, 4'd7, randByte());
      dataOp(COND_AL, CMD_ORR, 1'b0, 1'b0, 4'd7, 4'd8, 8'd1);
      for (int k = 1; k <= 8; k++) begin
         storeWord(regAddr_t'(k), 12'(4 * (k - 1)), $sformatf("arith R%0d", k));
      end

      // Load followed at once by a use
      storeWord(4'd8, 12'h040, "load-use source");
      loadWord(4'd9, 12'h040);
      dataOp(COND_AL, CMD_ADD, 1'b1, 1'b0, 4'd9, 4'd10, randByte());
      storeWord(4'd10, 12'h044, "load-use sum");

      branch(COND_AL, 24'd1);            // Skips the next two
      rawStore(4'd1, SKIP_A[11:0]);
      rawStore(4'd2, SKIP_B[11:0]);
      storeWord(4'd3, 12'h088, "branch target");

      x = randByte();
      y = randByte();
      if (y == x) y = ~x;
      dataOp(COND_AL, CMD_ADD, 1'b1, 1'b0, 4'd0, 4'd9, x);
      dataOp(COND_AL, CMD_AND, 1'b1, 1'b0, 4'd0, 4'd11, 8'd0);  // Counter
      conditionRun(x, 12'h048, "cond equal");
      conditionRun(y, 12'h04c, "cond unequal");

      dataOp(COND_AL, CMD_ADD, 1'b1, 1'b0, REG_PC, 4'd13, 8'd0);
      storeWord(4'd13, 12'h050, "r15 read");
      branch(COND_AL, 24'hfffffe);       // Spin here

      waitResetRelease();
      checkValue("reset pc", '0, pc);
      checkValue("reset memWrite", '0, {31'b0, memWrite});

      while (expAddr.size() > 0) begin
         waitStore(a, d);
         name = expName.pop_front();
         checkValue({name, " address"}, expAddr.pop_front(), a);
         checkValue({name, " data"}, expData.pop_front(), d);
      end
      @(negedge clk);
      checkValue("skipped word A", FILL ^ SKIP_A, dmem[SKIP_A[9:2]]);
      checkValue("skipped word B", FILL ^ SKIP_B, dmem[SKIP_B[9:2]]);

      $display("Finished with no errors");
      $finish;
   end

endmodule

// File: tb/clockGen.sv
/* Clock and reset source for the testbench
   100 ns clock, reset held for two rising edges */
module clockGen (
   output logic clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);   // Release on the falling edge
      reset = 1'b0;
   end

endmodule

// File: source/armPipe.sv
/* Five-stage pipelined processor for an ARM data, memory and branch subset
   Fetch, decode, execute and writeback stages with a hazard unit */
module armPipe (
   input  logic          clk,
   input  logic          reset,
   input  isaPkg::word_t instr,
   input  isaPkg::word_t readData,
   output isaPkg::word_t pc,
   output isaPkg::word_t dataAddr,
   output isaPkg::word_t writeData,
   output logic          memWrite
);
   import isaPkg::*;
   import pipePkg::*;

   word_t      instrD, pcPlus8D;
   regAddr_t   ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W;
   word_t      rd1E, rd2E, immE;
   aluCtrl_t   aluCtrlE;
   logic       aluSrcE, regWriteE, memWriteE, memToRegE, branchE;
   logic [1:0] flagWriteE;
   cond_t      condE;
   word_t      aluResultE, resultW;
   logic       branchTakenE;
   logic       regWriteM, memToRegM, regWriteW;
   fwdSel_t    fwdA, fwdB;
   logic       stallF, stallD, flushD, flushE;

   fetchStage fetch (
      .clk(clk), .reset(reset), .stallF(stallF), .stallD(stallD),
      .flushD(flushD), .branchTakenE(branchTakenE), .branchTarget(aluResultE),
      .instr(instr), .pc(pc), .instrD(instrD), .pcPlus8D(pcPlus8D)
   );

   decodeStage decode (
      .clk(clk), .reset(reset), .flushE(flushE), .instrD(instrD),
      .pcPlus8D(pcPlus8D), .resultW(resultW), .wa3W(wa3W), .regWriteW(regWriteW),
      .ra1D(ra1D), .ra2D(ra2D), .ra1E(ra1E), .ra2E(ra2E), .wa3E(wa3E),
      .rd1E(rd1E), .rd2E(rd2E), .immE(immE), .aluCtrlE(aluCtrlE),
      .aluSrcE(aluSrcE), .regWriteE(regWriteE), .memWriteE(memWriteE),
      .memToRegE(memToRegE), .branchE(branchE), .flagWriteE(flagWriteE),
      .condE(condE)
   );

   executeStage execute (
      .clk(clk), .reset(reset), .rd1E(rd1E), .rd2E(rd2E), .immE(immE),
      .wa3E(wa3E), .aluCtrlE(aluCtrlE), .aluSrcE(aluSrcE), .regWriteE(regWriteE),
      .memWriteE(memWriteE), .memToRegE(memToRegE), .branchE(branchE),
      .flagWriteE(flagWriteE), .condE(condE), .fwdA(fwdA), .fwdB(fwdB),
      .resultW(resultW), .aluResultE(aluResultE), .branchTakenE(branchTakenE),
      .dataAddr(dataAddr), .writeData(writeData), .memWrite(memWrite),
      .regWriteM(regWriteM), .memToRegM(memToRegM), .wa3M(wa3M)
   );

   writebackStage writeback (
      .clk(clk), .reset(reset), .dataAddr(dataAddr), .readData(readData),
      .regWriteM(regWriteM), .memToRegM(memToRegM), .wa3M(wa3M),
      .resultW(resultW), .regWriteW(regWriteW), .wa3W(wa3W)
   );

   hazardUnit hazard (
      .ra1D(ra1D), .ra2D(ra2D), .ra1E(ra1E), .ra2E(ra2E), .wa3E(wa3E),
      .wa3M(wa3M), .wa3W(wa3W), .regWriteM(regWriteM), .regWriteW(regWriteW),
      .memToRegE(memToRegE), .branchTakenE(branchTakenE), .fwdA(fwdA),
      .fwdB(fwdB), .stallF(stallF), .stallD(stallD), .flushD(flushD),
      .flushE(flushE)
   );

endmodule

// File: source/hazardUnit.sv
/* Hazard unit: operand forward selects, load-use stall
   and wrong-path flushes after a taken branch */
module hazardUnit (
   input  isaPkg::regAddr_t ra1D,
   input  isaPkg::regAddr_t ra2D,
   input  isaPkg::regAddr_t ra1E,
   input  isaPkg::regAddr_t ra2E,
   input  isaPkg::regAddr_t wa3E,
   input  isaPkg::regAddr_t wa3M,
   input  isaPkg::regAddr_t wa3W,
   input  logic             regWriteM,
   input  logic             regWriteW,
   input  logic             memToRegE,
   input  logic             branchTakenE,
   output pipePkg::fwdSel_t fwdA,
   output pipePkg::fwdSel_t fwdB,
   output logic             stallF,
   output logic             stallD,
   output logic             flushD,
   output logic             flushE
);
   import isaPkg::*;
   import pipePkg::*;

   logic loadUse;

   // Memory stage holds the younger result, so it goes first
   always_comb begin
      if (regWriteM && (wa3M == ra1E))      fwdA = FWD_MEM;
      else if (regWriteW && (wa3W == ra1E)) fwdA = FWD_WB;
      else                                  fwdA = FWD_NONE;

      if (regWriteM && (wa3M == ra2E))      fwdB = FWD_MEM;
      else if (regWriteW && (wa3W == ra2E)) fwdB = FWD_WB;
      else                                  fwdB = FWD_NONE;
   end

   // Loaded data is not ready until writeback
   assign loadUse = memToRegE && ((wa3E == ra1D) || (wa3E == ra2D));

   assign stallF = loadUse;
   assign stallD = loadUse;
   assign flushE = loadUse || branchTakenE;  // Bubble into execute
   assign flushD = branchTakenE;

endmodule

// File: source/writebackStage.sv
/* Writeback stage: memory/writeback register and result select */
module writebackStage (
   input  logic             clk,
   input  logic             reset,
   input  isaPkg::word_t    dataAddr,
   input  isaPkg::word_t    readData,
   input  logic             regWriteM,
   input  logic             memToRegM,
   input  isaPkg::regAddr_t wa3M,
   output isaPkg::word_t    resultW,
   output logic             regWriteW,
   output isaPkg::regAddr_t wa3W
);
   import isaPkg::*;

   word_t aluOutW;
   word_t readDataW;
   logic  memToRegW;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         {aluOutW, readDataW, wa3W} <= '0;
         {regWriteW, memToRegW} <= '0;
      end else begin
         aluOutW   <= dataAddr;   // ALU result of the memory stage
         readDataW <= readData;
         wa3W      <= wa3M;
         regWriteW <= regWriteM;
         memToRegW <= memToRegM;
      end
   end

   assign resultW = memToRegW ? readDataW : aluOutW;  // Loads take memory data

endmodule

// File: source/executeStage.sv
/* Execute stage: operand forwarding, ALU with NZCV, condition check
   against the flags register and the execute/memory register */
module executeStage (
   input  logic              clk,
   input  logic              reset,
   input  isaPkg::word_t     rd1E,
   input  isaPkg::word_t     rd2E,
   input  isaPkg::word_t     immE,
   input  isaPkg::regAddr_t  wa3E,
   input  pipePkg::aluCtrl_t aluCtrlE,
   input  logic              aluSrcE,
   input  logic              regWriteE,
   input  logic              memWriteE,
   input  logic              memToRegE,
   input  logic              branchE,
   input  logic [1:0]        flagWriteE,
   input  isaPkg::cond_t     condE,
   input  pipePkg::fwdSel_t  fwdA,
   input  pipePkg::fwdSel_t  fwdB,
   input  isaPkg::word_t     resultW,
   output isaPkg::word_t     aluResultE,
   output logic              branchTakenE,
   output isaPkg::word_t     dataAddr,
   output isaPkg::word_t     writeData,
   output logic              memWrite,
   output logic              regWriteM,
   output logic              memToRegM,
   output isaPkg::regAddr_t  wa3M
);
   import isaPkg::*;
   import pipePkg::*;

   word_t       srcA;
   word_t       srcB;
   word_t       writeDataE;
   word_t       addend;
   logic        isSub;
   logic [32:0] sum;        // Bit 32 is the carry out
   flags_t      aluFlags;
   flags_t      flagsE;     // Architectural NZCV
   logic        n, z, c, v;
   logic        condEx;

   function automatic word_t pickOperand(input fwdSel_t sel, input word_t regVal,
                                         input word_t memVal, input word_t wbVal);
      case (sel)
         FWD_MEM: return memVal;
         FWD_WB:  return wbVal;
         default: return regVal;
      endcase
   endfunction

   // dataAddr is the ALU result sitting in the memory stage
   assign srcA       = pickOperand(fwdA, rd1E, dataAddr, resultW);
   assign writeDataE = pickOperand(fwdB, rd2E, dataAddr, resultW);
   assign srcB       = aluSrcE ? immE : writeDataE;

   assign isSub  = (aluCtrlE == ALU_SUB);
   assign addend = isSub ? ~srcB : srcB;   // Subtract as a + ~b + 1
   assign sum    = {1'b0, srcA} + {1'b0, addend} + {32'b0, isSub};

   always_comb begin
      case (aluCtrlE)
         ALU_AND: aluResultE = srcA & srcB;
         ALU_ORR: aluResultE = srcA | srcB;
         default: aluResultE = sum[31:0];
      endcase
   end

   assign aluFlags[3] = aluResultE[31];
   assign aluFlags[2] = (aluResultE == '0);
   assign aluFlags[1] = sum[32];
   assign aluFlags[0] = ~(srcA[31] ^ srcB[31] ^ isSub) & (srcA[31] ^ sum[31]);

   assign {n, z, c, v} = flagsE;

   always_comb begin
      case (condE)
         COND_EQ: condEx = z;
         COND_NE: condEx = !z;
         COND_CS: condEx = c;
         COND_CC: condEx = !c;
         COND_MI: condEx = n;
         COND_PL: condEx = !n;
         COND_VS: condEx = v;
         COND_VC: condEx = !v;
         COND_HI: condEx = c && !z;
         COND_LS: condEx = !c || z;
         COND_GE: condEx = (n == v);
         COND_LT: condEx = (n != v);
         COND_GT: condEx = !z && (n == v);
         COND_LE: condEx = z || (n != v);
         COND_AL: condEx = 1'b1;
         default: condEx = 1'b0;   // Unconditional space not supported
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flagsE <= '0;
      end else if (condEx) begin
         if (flagWriteE[1]) flagsE[3:2] <= aluFlags[3:2];
         if (flagWriteE[0]) flagsE[1:0] <= aluFlags[1:0];
      end
   end

   assign branchTakenE = branchE & condEx;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         {dataAddr, writeData, wa3M} <= '0;
         {memWrite, regWriteM, memToRegM} <= '0;
      end else begin
         dataAddr  <= aluResultE;
         writeData <= writeDataE;
         wa3M      <= wa3E;
         memWrite  <= memWriteE & condEx;   // Failed condition squashes
         regWriteM <= regWriteE & condEx;
         memToRegM <= memToRegE;
      end
   end

endmodule

// File: source/decodeStage.sv
/* Decode stage: control decoder, register file with R15 as PC+8,
   immediate extension and the decode/execute register */
module decodeStage (
   input  logic              clk,
   input  logic              reset,
   input  logic              flushE,
   input  isaPkg::word_t     instrD,
   input  isaPkg::word_t     pcPlus8D,
   input  isaPkg::word_t     resultW,
   input  isaPkg::regAddr_t  wa3W,
   input  logic              regWriteW,
   output isaPkg::regAddr_t  ra1D,
   output isaPkg::regAddr_t  ra2D,
   output isaPkg::regAddr_t  ra1E,
   output isaPkg::regAddr_t  ra2E,
   output isaPkg::regAddr_t  wa3E,
   output isaPkg::word_t     rd1E,
   output isaPkg::word_t     rd2E,
   output isaPkg::word_t     immE,
   output pipePkg::aluCtrl_t aluCtrlE,
   output logic              aluSrcE,
   output logic              regWriteE,
   output logic              memWriteE,
   output logic              memToRegE,
   output logic              branchE,
   output logic [1:0]        flagWriteE,
   output isaPkg::cond_t     condE
);
   import isaPkg::*;
   import pipePkg::*;

   word_t      regs [0:14];  // R0 to R14, R15 is not stored
   logic [1:0] op;
   logic [3:0] cmd;
   logic       immBit;
   logic       sBit;         // Same bit is L for loads and stores
   immSrc_t    immSrcD;
   aluCtrl_t   aluCtrlD;
   logic       aluSrcD;
   logic       regWriteD;
   logic       memWriteD;
   logic       memToRegD;
   logic       branchD;
   logic [1:0] flagWriteD;   // {NZ, CV}
   word_t      rd1D;
   word_t      rd2D;
   word_t      immD;

   assign op     = instrD[27:26];
   assign immBit = instrD[25];
   assign cmd    = instrD[24:21];
   assign sBit   = instrD[20];

   always_comb begin
      immSrcD    = IMM_DATA8;
      aluCtrlD   = ALU_ADD;
      aluSrcD    = 1'b0;
      regWriteD  = 1'b0;
      memWriteD  = 1'b0;
      memToRegD  = 1'b0;
      branchD    = 1'b0;
      flagWriteD = 2'b00;
      case (op)
         OP_DATA: begin
            aluSrcD   = immBit;
            regWriteD = 1'b1;
            case (cmd)
               CMD_ADD: aluCtrlD = ALU_ADD;
               CMD_SUB: aluCtrlD = ALU_SUB;
               CMD_AND: aluCtrlD = ALU_AND;
               CMD_ORR: aluCtrlD = ALU_ORR;
               default: regWriteD = 1'b0;  // Unsupported command
            endcase
            flagWriteD[1] = sBit & regWriteD;
            flagWriteD[0] = sBit & ((cmd == CMD_ADD) || (cmd == CMD_SUB));
         end
         OP_MEM: begin
            immSrcD   = IMM_MEM12;
            aluSrcD   = 1'b1;
            regWriteD = sBit;     // LDR
            memToRegD = sBit;
            memWriteD = !sBit;    // STR
         end
         OP_BRANCH: begin
            immSrcD = IMM_BRANCH24;
            aluSrcD = 1'b1;       // Target is R15 plus offset
            branchD = 1'b1;
         end
         default: ;
      endcase
   end

   // Branch reads R15, a store reads its data register as source 2
   assign ra1D = (op == OP_BRANCH) ? REG_PC : instrD[19:16];
   assign ra2D = (op == OP_MEM) ? instrD[15:12] : instrD[3:0];

   // Write on the falling edge so decode sees the value in the same cycle
   always_ff @(negedge clk) begin
      if (regWriteW && (wa3W != REG_PC)) begin
         regs[wa3W] <= resultW;
      end
   end

   assign rd1D = (ra1D == REG_PC) ? pcPlus8D : regs[ra1D];
   assign rd2D = (ra2D == REG_PC) ? pcPlus8D : regs[ra2D];

   always_comb begin
      case (immSrcD)
         IMM_MEM12:    immD = {20'b0, instrD[11:0]};
         IMM_BRANCH24: immD = {{6{instrD[23]}}, instrD[23:0], 2'b00};
         default:      immD = {24'b0, instrD[7:0]};
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         {ra1E, ra2E, wa3E, condE} <= '0;
         {rd1E, rd2E, immE} <= '0;
         aluCtrlE <= ALU_ADD;
         aluSrcE  <= 1'b0;
         {regWriteE, memWriteE, memToRegE, branchE, flagWriteE} <= '0;
      end else begin
         ra1E     <= ra1D;
         ra2E     <= ra2D;
         wa3E     <= instrD[15:12];
         condE    <= instrD[31:28];
         rd1E     <= rd1D;
         rd2E     <= rd2D;
         immE     <= immD;
         aluCtrlE <= aluCtrlD;
         aluSrcE  <= aluSrcD;
         if (flushE) begin
            {regWriteE, memWriteE, memToRegE, branchE, flagWriteE} <= '0;
         end else begin
            regWriteE  <= regWriteD;
            memWriteE  <= memWriteD;
            memToRegE  <= memToRegD;
            branchE    <= branchD;
            flagWriteE <= flagWriteD;
         end
      end
   end

endmodule

// File: source/fetchStage.sv
/* Fetch stage: PC register with branch redirect,
   plus the fetch/decode pipeline register */
module fetchStage (
   input  logic          clk,
   input  logic          reset,
   input  logic          stallF,
   input  logic          stallD,
   input  logic          flushD,
   input  logic          branchTakenE,
   input  isaPkg::word_t branchTarget,
   input  isaPkg::word_t instr,
   output isaPkg::word_t pc,
   output isaPkg::word_t instrD,
   output isaPkg::word_t pcPlus8D
);
   import isaPkg::*;

   word_t pcPlus4F;

   assign pcPlus4F = pc + PC_STEP;
   assign pcPlus8D = pcPlus4F;  // Fetch runs one word ahead of decode

   // Taken branch wins over a stall
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pc <= '0;
      end else if (branchTakenE) begin
         pc <= branchTarget;
      end else if (!stallF) begin
         pc <= pcPlus4F;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         instrD <= '0;
      end else if (flushD) begin
         instrD <= '0;   // Wrong-path slot becomes a bubble
      end else if (!stallD) begin
         instrD <= instr;
      end
   end

endmodule

// File: source/pipePkg.sv
/* Pipeline control encodings
   ALU operation, immediate kind and operand forward select */
package pipePkg;

   typedef logic [1:0] aluCtrl_t;
   typedef logic [1:0] immSrc_t;
   typedef logic [1:0] fwdSel_t;

   // ALU operation
   localparam aluCtrl_t ALU_ADD = 2'd0;
   localparam aluCtrl_t ALU_SUB = 2'd1;
   localparam aluCtrl_t ALU_AND = 2'd2;
   localparam aluCtrl_t ALU_ORR = 2'd3;

   // Immediate kind chosen by the decoder
   localparam immSrc_t IMM_DATA8    = 2'd0;  // Zero-extended 8 bits
   localparam immSrc_t IMM_MEM12    = 2'd1;  // Zero-extended 12 bits
   localparam immSrc_t IMM_BRANCH24 = 2'd2;  // Signed word offset

   // Execute operand source
   localparam fwdSel_t FWD_NONE = 2'd0;
   localparam fwdSel_t FWD_WB   = 2'd1;
   localparam fwdSel_t FWD_MEM  = 2'd2;

endpackage

// File: source/isaPkg.sv
/* Instruction set definitions for the pipelined ARM subset
   Data widths, instruction field values and condition codes */
package isaPkg;

   typedef logic [31:0] word_t;     // Data word and byte address
   typedef logic [3:0]  regAddr_t;
   typedef logic [3:0]  cond_t;
   typedef logic [3:0]  flags_t;    // {N, Z, C, V}

   // Op field, instr[27:26]
   localparam logic [1:0] OP_DATA   = 2'd0;
   localparam logic [1:0] OP_MEM    = 2'd1;
   localparam logic [1:0] OP_BRANCH = 2'd2;

   // Data processing command, instr[24:21]
   localparam logic [3:0] CMD_ADD = 4'd4;
   localparam logic [3:0] CMD_SUB = 4'd2;
   localparam logic [3:0] CMD_AND = 4'd0;
   localparam logic [3:0] CMD_ORR = 4'd12;

   // Condition field, instr[31:28]
   localparam cond_t COND_EQ = 4'h0;   // Z set
   localparam cond_t COND_NE = 4'h1;
   localparam cond_t COND_CS = 4'h2;   // C set
   localparam cond_t COND_CC = 4'h3;
   localparam cond_t COND_MI = 4'h4;   // N set
   localparam cond_t COND_PL = 4'h5;
   localparam cond_t COND_VS = 4'h6;   // V set
   localparam cond_t COND_VC = 4'h7;
   localparam cond_t COND_HI = 4'h8;   // Unsigned higher
   localparam cond_t COND_LS = 4'h9;
   localparam cond_t COND_GE = 4'ha;   // Signed compares
   localparam cond_t COND_LT = 4'hb;
   localparam cond_t COND_GT = 4'hc;
   localparam cond_t COND_LE = 4'hd;
   localparam cond_t COND_AL = 4'he;

   // R15 reads as the decoding address plus 8
   localparam regAddr_t REG_PC = 4'd15;

   localparam word_t PC_STEP = 32'd4;

endpackage
